/* bench/dram_model.sv */
`timescale 1ns/1ps
`default_nettype none

module dram_model #(
    parameter int SEED = 1
) (
    input  wire                             clk_dram_ctrl,
    input  wire                             i_mem_en,
    input  wire dram_traffic_pkg::mem_req_t i_mem_req,
    output logic                            o_mem_busy,
    output logic                            o_mem_complete,
    output dram_traffic_pkg::data_t         o_mem_resp,
    output logic                            o_seen,
    output dram_traffic_pkg::mem_req_t      o_seen_req
);

    // sparse burst storage
    dram_traffic_pkg::data_t mem [dram_traffic_pkg::addr_t];
    // accepted but not yet acked with oldest first
    dram_traffic_pkg::data_t resp_q [$];
    int unsigned             due_q [$];
    int unsigned             cyc      = 0;
    int unsigned             last_due = 0;
    int unsigned             due;
    int                      seed     = SEED;

    // quiet port until the first falling edge
    initial begin
        o_mem_busy     = 1'b1;
        o_mem_complete = 1'b0;
        o_mem_resp     = '0;
        o_seen         = 1'b0;
        o_seen_req     = '0;
    end

    // outputs move on the falling edge and the DUT samples on the rising one
    always @(negedge clk_dram_ctrl) begin
        cyc = cyc + 1;
        o_mem_complete = 1'b0;
        if (due_q.size() > 0 && due_q[0] <= cyc) begin
            o_mem_complete = 1'b1;
            o_mem_resp     = resp_q.pop_front();
            void'(due_q.pop_front());
        end
        // stall roughly one cycle in three
        o_mem_busy = ($unsigned($random(seed)) % 3) == 0;
        // accepted on the coming rising edge
        o_seen     = (i_mem_en === 1'b1) && !o_mem_busy;
        o_seen_req = i_mem_req;
        if (o_seen) begin
            // 1 to 6 cycles and never ahead of an older request
            due = cyc + 1 + ($unsigned($random(seed)) % 6);
            if (due <= last_due) begin
                due = last_due + 1;
            end
            last_due = due;
            due_q.push_back(due);
            if (i_mem_req.wr) begin
                mem[i_mem_req.addr] = i_mem_req.wdata;
                resp_q.push_back('0);
            end else if (mem.exists(i_mem_req.addr)) begin
                resp_q.push_back(mem[i_mem_req.addr]);
            end else begin
                // unwritten burst gets a pattern built from the whole address
                resp_q.push_back(dram_traffic_pkg::data_t'({5{i_mem_req.addr}}));
            end
        end
    end

endmodule

`default_nettype wire

/* bench/tb_dram_traffic.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dram_traffic_defs.svh"

module tb_dram_traffic;

    localparam int N_LOAD   = 16;
    localparam int N_READ   = 64;
    localparam int MAX_CYC  = (N_LOAD + N_READ) * 40;
    localparam int SEED_VAL = 50487;

    logic                       clk_dram_ctrl = 1'b1;
    logic                       rst_dram_ctrl;
    dram_traffic_pkg::data_t    load_data;
    logic                       load_last;
    logic                       load_valid;
    logic                       load_ready;
    dram_traffic_pkg::addr_t    rd_addr;
    logic                       rd_valid;
    logic                       rd_ready;
    logic                       mem_busy;
    logic                       mem_complete;
    dram_traffic_pkg::data_t    mem_resp;
    logic                       mem_en;
    dram_traffic_pkg::mem_req_t mem_req;
    dram_traffic_pkg::data_t    rd_data;
    logic                       rd_data_valid;
    logic                       load_complete;
    dram_traffic_pkg::count_t   complete_count;
    logic                       mem_seen;
    dram_traffic_pkg::mem_req_t mem_seen_req;

    // beats sent by offset from the load base
    dram_traffic_pkg::data_t    load_beats [N_LOAD];
    dram_traffic_pkg::addr_t    rd_addr_q [$];
    dram_traffic_pkg::addr_t    head_addr;
    logic                       kind_q [$];
    int seed;
    int n_errors;
    int n_checks;
    int cycles;
    int wr_seen;
    int wr_done;
    int rd_done;
    int accepted;
    int gap;
    logic live;

    always #2 clk_dram_ctrl = ~clk_dram_ctrl;

    dram_traffic_top dram_traffic_top_inst (
        .clk_dram_ctrl    (clk_dram_ctrl),
        .rst_dram_ctrl    (rst_dram_ctrl),
        .i_load_data      (load_data),
        .i_load_last      (load_last),
        .i_load_valid     (load_valid),
        .i_rd_addr        (rd_addr),
        .i_rd_valid       (rd_valid),
        .i_mem_busy       (mem_busy),
        .i_mem_complete   (mem_complete),
        .i_mem_resp       (mem_resp),
        .o_load_ready     (load_ready),
        .o_rd_ready       (rd_ready),
        .o_mem_en         (mem_en),
        .o_mem_req        (mem_req),
        .o_rd_data        (rd_data),
        .o_rd_data_valid  (rd_data_valid),
        .o_load_complete  (load_complete),
        .o_complete_count (complete_count)
    );

    dram_model #(.SEED(SEED_VAL)) dram_model_inst (
        .clk_dram_ctrl  (clk_dram_ctrl),
        .i_mem_en       (mem_en),
        .i_mem_req      (mem_req),
        .o_mem_busy     (mem_busy),
        .o_mem_complete (mem_complete),
        .o_mem_resp     (mem_resp),
        .o_seen         (mem_seen),
        .o_seen_req     (mem_seen_req)
    );

    // expected burst at an address, from the load pattern
    function automatic dram_traffic_pkg::data_t expected_read(input dram_traffic_pkg::addr_t a);
        int idx;
        idx = int'(a) - `LOAD_BASE_ADDR;
        return load_beats[idx];
    endfunction

    task automatic check_data(input dram_traffic_pkg::data_t got,
                              input dram_traffic_pkg::data_t exp, input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_addr(input dram_traffic_pkg::addr_t got,
                              input dram_traffic_pkg::addr_t exp, input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input dram_traffic_pkg::count_t got,
                               input dram_traffic_pkg::count_t exp, input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Error at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // starts on a falling edge and returns on the one after the transfer
    task automatic send_load(input dram_traffic_pkg::data_t d, input logic last);
        load_data  = d;
        load_last  = last;
        load_valid = 1'b1;
        while (!load_ready) @(negedge clk_dram_ctrl);
        @(negedge clk_dram_ctrl);
        load_valid = 1'b0;
    endtask

    task automatic send_read(input dram_traffic_pkg::addr_t a);
        rd_addr  = a;
        rd_valid = 1'b1;
        while (!rd_ready) @(negedge clk_dram_ctrl);
        rd_addr_q.push_back(a);
        @(negedge clk_dram_ctrl);
        rd_valid = 1'b0;
    endtask

    // memory port monitor at the rising edge where model outputs are steady
    always @(posedge clk_dram_ctrl) begin
        live = !rst_dram_ctrl;
        if (!rst_dram_ctrl) begin
            if (mem_seen) begin
                accepted++;
                kind_q.push_back(mem_seen_req.wr);
                if (mem_seen_req.wr && wr_seen >= N_LOAD) begin
                    n_errors++;
                    $display("Error at %0t: more writes than load beats reached memory", $time);
                end else if (mem_seen_req.wr) begin
                    check_addr(mem_seen_req.addr,
                               dram_traffic_pkg::addr_t'(`LOAD_BASE_ADDR + wr_seen), "write addr");
                    check_data(mem_seen_req.wdata, load_beats[wr_seen], "write data");
                    wr_seen++;
                end
            end
            if (mem_complete && kind_q.size() == 0) begin
                n_errors++;
                $display("Error at %0t: memory acked a request that was never issued", $time);
            end else if (mem_complete && kind_q.pop_front()) begin
                wr_done++;
            end
        end
    end

    // DUT outputs checked mid-cycle
    always @(negedge clk_dram_ctrl) begin
        if (live) begin
            check_flag(load_complete, wr_done == N_LOAD, "load complete");
            if (wr_done < N_LOAD) begin
                check_flag(rd_ready, 1'b0, "read ready during load");
            end
            // writer is DONE once every beat went out to memory
            if (wr_seen == N_LOAD) begin
                check_flag(load_ready, 1'b0, "load ready after last beat");
            end
            if (rd_data_valid && rd_addr_q.size() == 0) begin
                n_errors++;
                $display("Error at %0t: read data strobe with no read outstanding", $time);
            end else if (rd_data_valid) begin
                head_addr = rd_addr_q.pop_front();
                check_data(rd_data, expected_read(head_addr), "read data");
                rd_done++;
            end
        end
    end

    always @(posedge clk_dram_ctrl) begin
        cycles++;
        if (cycles >= MAX_CYC) begin
            $display("timeout: traffic did not finish within %0d cycles", MAX_CYC);
            $display("tests failed");
            $finish;
        end
    end

    initial begin
        seed       = SEED_VAL;
        n_errors   = 0;
        n_checks   = 0;
        cycles     = 0;
        wr_seen    = 0;
        wr_done    = 0;
        rd_done    = 0;
        accepted   = 0;
        live       = 1'b0;
        rst_dram_ctrl = 1'b1;
        load_data  = '0;
        load_last  = 1'b0;
        load_valid = 1'b0;
        rd_addr    = '0;
        rd_valid   = 1'b0;
        for (int k = 0; k < N_LOAD; k++) begin
            for (int j = 0; j < 4; j++) begin
                load_beats[k][32*j +: 32] = $random(seed);
            end
        end
        repeat (5) @(posedge clk_dram_ctrl);
        @(negedge clk_dram_ctrl);
        // idle state out of reset
        check_flag(mem_en, 1'b0, "enable after reset");
        check_flag(rd_ready, 1'b0, "read ready after reset");
        check_flag(rd_data_valid, 1'b0, "read strobe after reset");
        check_flag(load_complete, 1'b0, "load complete after reset");
        check_count(complete_count, '0, "count after reset");
        rst_dram_ctrl = 1'b0;
        for (int k = 0; k < N_LOAD; k++) begin
            send_load(load_beats[k], k == N_LOAD - 1);
        end
        // reads stall on ready until the load is acked
        for (int k = 0; k < N_READ; k++) begin
            gap = $unsigned($random(seed)) % 3;
            repeat (gap) @(negedge clk_dram_ctrl);
            send_read(dram_traffic_pkg::addr_t'(`LOAD_BASE_ADDR
                                                + ($unsigned($random(seed)) % N_LOAD)));
        end
        while (rd_done < N_READ) @(negedge clk_dram_ctrl);
        check_count(dram_traffic_pkg::count_t'(wr_seen), N_LOAD, "writes at memory");
        check_count(dram_traffic_pkg::count_t'(accepted), N_LOAD + N_READ, "accepted requests");
        check_count(complete_count, N_LOAD + N_READ, "completion count");
        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* dram_traffic.f */
+incdir+hw
hw/dram_traffic_pkg.sv
hw/load_writer.sv
hw/request_arbiter.sv
hw/inflight_tracker.sv
hw/dram_traffic_top.sv
bench/dram_model.sv
bench/tb_dram_traffic.sv

/* hw/dram_traffic_defs.svh */
`ifndef DRAM_TRAFFIC_DEFS_SVH
`define DRAM_TRAFFIC_DEFS_SVH

// burst-addressable memory, one 128-bit burst per address
`define ADDR_W 24
`define DATA_W 128

// running count of acknowledged requests
`define COUNT_W 16

// first burst address of the sample load
`define LOAD_BASE_ADDR 0

// max unacknowledged requests at the memory port
`define INFLIGHT_DEPTH 4

`endif

/* hw/dram_traffic_pkg.sv */
`default_nettype none

`include "dram_traffic_defs.svh"

package dram_traffic_pkg;

    typedef logic [`ADDR_W-1:0]  addr_t;
    typedef logic [`DATA_W-1:0]  data_t;
    typedef logic [`COUNT_W-1:0] count_t;

    // one request at the memory port
    typedef struct packed {
        addr_t addr;
        logic  wr;
        data_t wdata;
    } mem_req_t;

    // what the tracker needs to know per issued request
    typedef struct packed {
        logic is_read;
        logic is_last;
    } req_tag_t;

    typedef enum logic {
        LOADING,
        DONE
    } writer_state_t;

    typedef enum logic {
        IDLE,
        HOLD
    } arb_state_t;

endpackage

`default_nettype wire

/* hw/dram_traffic_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dram_traffic_top (
    input  wire                             clk_dram_ctrl,
    input  wire                             rst_dram_ctrl,
    input  wire dram_traffic_pkg::data_t    i_load_data,
    input  wire                             i_load_last,
    input  wire                             i_load_valid,
    input  wire dram_traffic_pkg::addr_t    i_rd_addr,
    input  wire                             i_rd_valid,
    input  wire                             i_mem_busy,
    input  wire                             i_mem_complete,
    input  wire dram_traffic_pkg::data_t    i_mem_resp,
    output logic                            o_load_ready,
    output logic                            o_rd_ready,
    output logic                            o_mem_en,
    output dram_traffic_pkg::mem_req_t      o_mem_req,
    output dram_traffic_pkg::data_t         o_rd_data,
    output logic                            o_rd_data_valid,
    output logic                            o_load_complete,
    output dram_traffic_pkg::count_t        o_complete_count
);

    // writer to arbiter
    dram_traffic_pkg::mem_req_t wr_req;
    logic                       wr_valid;
    logic                       wr_last;
    logic                       take;

    // arbiter to tracker
    logic                       issue;
    dram_traffic_pkg::req_tag_t issue_tag;
    logic                       tracker_full;

    load_writer load_writer_inst (
        .clk_dram_ctrl (clk_dram_ctrl),
        .rst_dram_ctrl (rst_dram_ctrl),
        .i_load_data   (i_load_data),
        .i_load_last   (i_load_last),
        .i_load_valid  (i_load_valid),
        .i_take        (take),
        .o_load_ready  (o_load_ready),
        .o_wr_req      (wr_req),
        .o_wr_valid    (wr_valid),
        .o_wr_last     (wr_last)
    );

    request_arbiter request_arbiter_inst (
        .clk_dram_ctrl   (clk_dram_ctrl),
        .rst_dram_ctrl   (rst_dram_ctrl),
        .i_wr_req        (wr_req),
        .i_wr_valid      (wr_valid),
        .i_wr_last       (wr_last),
        .i_rd_addr       (i_rd_addr),
        .i_rd_valid      (i_rd_valid),
        .i_load_complete (o_load_complete),
        .i_tracker_full  (tracker_full),
        .i_mem_busy      (i_mem_busy),
        .o_take          (take),
        .o_rd_ready      (o_rd_ready),
        .o_mem_en        (o_mem_en),
        .o_mem_req       (o_mem_req),
        .o_issue         (issue),
        .o_issue_tag     (issue_tag)
    );

    inflight_tracker inflight_tracker_inst (
        .clk_dram_ctrl    (clk_dram_ctrl),
        .rst_dram_ctrl    (rst_dram_ctrl),
        .i_issue          (issue),
        .i_issue_tag      (issue_tag),
        .i_mem_complete   (i_mem_complete),
        .i_mem_resp       (i_mem_resp),
        .o_full           (tracker_full),
        .o_rd_data        (o_rd_data),
        .o_rd_data_valid  (o_rd_data_valid),
        .o_load_complete  (o_load_complete),
        .o_complete_count (o_complete_count)
    );

endmodule

`default_nettype wire

/* hw/inflight_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dram_traffic_defs.svh"

module inflight_tracker (
    input  wire                             clk_dram_ctrl,
    input  wire                             rst_dram_ctrl,
    input  wire                             i_issue,
    input  wire dram_traffic_pkg::req_tag_t i_issue_tag,
    input  wire                             i_mem_complete,
    input  wire dram_traffic_pkg::data_t    i_mem_resp,
    output logic                            o_full,
    output dram_traffic_pkg::data_t         o_rd_data,
    output logic                            o_rd_data_valid,
    output logic                            o_load_complete,
    output dram_traffic_pkg::count_t        o_complete_count
);

    localparam int DEPTH  = `INFLIGHT_DEPTH;
    localparam int PTR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int FILL_W = $clog2(DEPTH + 1);

    // tags of issued requests, oldest at rd_ptr
    dram_traffic_pkg::req_tag_t tag_mem [DEPTH];
    logic [PTR_W-1:0]           wr_ptr;
    logic [PTR_W-1:0]           rd_ptr;
    logic [FILL_W-1:0]          fill;
    dram_traffic_pkg::req_tag_t head_tag;

    assign head_tag = tag_mem[rd_ptr];
    assign o_full   = (fill == FILL_W'(DEPTH));

    // tag storage
    always_ff @(posedge clk_dram_ctrl) begin
        if (i_issue) begin
            tag_mem[wr_ptr] <= i_issue_tag;
        end
    end

    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (i_issue) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            // completions come back in issue order
            if (i_mem_complete) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({i_issue, i_mem_complete})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    // completion routing, one cycle after the ack
    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            o_rd_data_valid  <= 1'b0;
            o_load_complete  <= 1'b0;
            o_complete_count <= '0;
        end else begin
            o_rd_data_valid <= i_mem_complete && head_tag.is_read;
            if (i_mem_complete) begin
                o_complete_count <= o_complete_count + 1'b1;
                // last load beat acked, sticky
                if (!head_tag.is_read && head_tag.is_last) begin
                    o_load_complete <= 1'b1;
                end
            end
        end
    end

    // read payload
    always_ff @(posedge clk_dram_ctrl) begin
        if (i_mem_complete && head_tag.is_read) begin
            o_rd_data <= i_mem_resp;
        end
    end

    // memory must never ack something that was not issued
    a_no_complete_when_empty: assert property (
        @(posedge clk_dram_ctrl) disable iff (rst_dram_ctrl)
        i_mem_complete |-> (fill != '0)
    );

endmodule

`default_nettype wire

/* hw/load_writer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dram_traffic_defs.svh"

module load_writer (
    input  wire                         clk_dram_ctrl,
    input  wire                         rst_dram_ctrl,
    input  wire dram_traffic_pkg::data_t i_load_data,
    input  wire                         i_load_last,
    input  wire                         i_load_valid,
    input  wire                         i_take,
    output logic                        o_load_ready,
    output dram_traffic_pkg::mem_req_t  o_wr_req,
    output logic                        o_wr_valid,
    output logic                        o_wr_last
);

    dram_traffic_pkg::writer_state_t state;
    dram_traffic_pkg::addr_t         wr_addr;
    dram_traffic_pkg::data_t         beat_data;
    logic                            beat_last;
    logic                            beat_full;
    logic                            beat_accept;

    // single beat register refilled only once the arbiter took it
    assign o_load_ready = !beat_full && (state == dram_traffic_pkg::LOADING);
    assign beat_accept  = i_load_valid && o_load_ready;

    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            state     <= dram_traffic_pkg::LOADING;
            wr_addr   <= dram_traffic_pkg::addr_t'(`LOAD_BASE_ADDR);
            beat_full <= 1'b0;
        end else begin
            if (beat_accept) begin
                beat_full <= 1'b1;
            end else if (i_take) begin
                // beat left for memory so the next one goes one burst higher
                beat_full <= 1'b0;
                wr_addr   <= wr_addr + 1'b1;
                if (beat_last) begin
                    state <= dram_traffic_pkg::DONE;
                end
            end
        end
    end

    // beat payload
    always_ff @(posedge clk_dram_ctrl) begin
        if (beat_accept) begin
            beat_data <= i_load_data;
            beat_last <= i_load_last;
        end
    end

    // write request as seen by the arbiter
    assign o_wr_req.addr  = wr_addr;
    assign o_wr_req.wr    = 1'b1;
    assign o_wr_req.wdata = beat_data;
    assign o_wr_valid     = beat_full;
    assign o_wr_last      = beat_last;

    // no take without a held beat and so no write after DONE
    a_take_only_held_beat: assert property (
        @(posedge clk_dram_ctrl) disable iff (rst_dram_ctrl)
        i_take |-> beat_full
    );

endmodule

`default_nettype wire

/* hw/request_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module request_arbiter (
    input  wire                              clk_dram_ctrl,
    input  wire                              rst_dram_ctrl,
    input  wire dram_traffic_pkg::mem_req_t  i_wr_req,
    input  wire                              i_wr_valid,
    input  wire                              i_wr_last,
    input  wire dram_traffic_pkg::addr_t     i_rd_addr,
    input  wire                              i_rd_valid,
    input  wire                              i_load_complete,
    input  wire                              i_tracker_full,
    input  wire                              i_mem_busy,
    output logic                             o_take,
    output logic                             o_rd_ready,
    output logic                             o_mem_en,
    output dram_traffic_pkg::mem_req_t       o_mem_req,
    output logic                             o_issue,
    output dram_traffic_pkg::req_tag_t       o_issue_tag
);

    dram_traffic_pkg::arb_state_t state;
    dram_traffic_pkg::mem_req_t   req_hold;
    dram_traffic_pkg::req_tag_t   tag_hold;
    logic                         can_select;
    logic                         sel_wr;
    logic                         sel_rd;

    // new selection only from IDLE and with room in the tracker
    assign can_select = (state == dram_traffic_pkg::IDLE) && !i_tracker_full;

    // writes first, reads only after the load finished
    assign sel_wr     = can_select && i_wr_valid;
    assign o_rd_ready = can_select && !i_wr_valid && i_load_complete;
    assign sel_rd     = o_rd_ready && i_rd_valid;

    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            state <= dram_traffic_pkg::IDLE;
        end else begin
            case (state)
                dram_traffic_pkg::IDLE: begin
                    if (sel_wr || sel_rd) begin
                        state <= dram_traffic_pkg::HOLD;
                    end
                end
                dram_traffic_pkg::HOLD: begin
                    // accepted once busy drops
                    if (!i_mem_busy) begin
                        state <= dram_traffic_pkg::IDLE;
                    end
                end
                default: begin
                    state <= dram_traffic_pkg::IDLE;
                end
            endcase
        end
    end

    // request and tag payload, captured at selection
    always_ff @(posedge clk_dram_ctrl) begin
        if (sel_wr) begin
            req_hold         <= i_wr_req;
            tag_hold.is_read <= 1'b0;
            tag_hold.is_last <= i_wr_last;
        end else if (sel_rd) begin
            req_hold.addr    <= i_rd_addr;
            req_hold.wr      <= 1'b0;
            req_hold.wdata   <= '0;
            tag_hold.is_read <= 1'b1;
            tag_hold.is_last <= 1'b0;
        end
    end

    // enable follows selection by one cycle
    assign o_mem_en  = (state == dram_traffic_pkg::HOLD);
    assign o_mem_req = req_hold;

    // acceptance cycle
    assign o_issue     = o_mem_en && !i_mem_busy;
    assign o_issue_tag = tag_hold;

    // writer keeps its beat until the write really went out
    assign o_take = o_issue && !tag_hold.is_read;

    // a stalled request must not move
    a_stable_while_busy: assert property (
        @(posedge clk_dram_ctrl) disable iff (rst_dram_ctrl)
        (o_mem_en && i_mem_busy) |=> o_mem_en && $stable(o_mem_req)
    );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build the testbench with verilator, run it, decide on the printed result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f dram_traffic.f \
    --top-module tb_dram_traffic -o sim_dram_traffic || exit 1

out=$(./obj_dir/sim_dram_traffic)
echo "$out"
echo "$out" | grep -qx "all tests passed" && echo "simulation PASSED" || { echo "simulation FAILED"; exit 1; }
